// File: ppu_pkg.sv
package ppu_pkg;

    // External memory words and addresses
    typedef logic [7:0]  oam_addr_t;
    typedef logic [31:0] oam_word_t;
    typedef logic [31:0] gfx_word_t;

    // Tile id times 16 plus the row
    typedef logic [10:0] gfx_addr_t;

    // Sprite bookkeeping
    typedef logic [6:0]  sprite_index_t;
    typedef logic [9:0]  vcount_t;
    typedef logic [15:0] sprite_y_t;
    typedef logic [6:0]  tile_id_t;
    typedef logic [3:0]  sprite_row_t;

    // Sprites found on one line, 0 to 8
    typedef logic [3:0]  slot_count_t;

    // Lines covered by one sprite
    localparam int SPRITE_HEIGHT = 16;

    // One decoded sprite table entry
    typedef struct packed {
        sprite_y_t y;
        tile_id_t  tile_id;
        logic      palette;
        logic      vflip;
        logic      hflip;
    } sprite_attr_t;

    // One graphics row handed to the shift registers
    typedef struct packed {
        logic      palette;
        gfx_word_t pixels;
    } sprite_slot_t;

endpackage

// File: oam_loader.sv
`timescale 1ns/100ps

module oam_loader #(
    parameter int NUM_SPRITES = 128
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   vblank,
    input  ppu_pkg::oam_word_t     oam_rdata,
    output ppu_pkg::oam_addr_t     oam_addr,
    output logic                   table_wr,
    output ppu_pkg::sprite_index_t table_wr_index,
    output ppu_pkg::sprite_attr_t  table_wr_attr
);
    import ppu_pkg::*;

    typedef enum logic [1:0] {
        LOAD_IDLE,
        LOAD_ACTIVE,
        LOAD_DONE
    } load_phase_t;

    // Last word position in presentation order
    localparam oam_addr_t LAST_WORD = oam_addr_t'(2 * NUM_SPRITES - 1);

    load_phase_t phase;
    oam_addr_t   word_ptr;
    oam_addr_t   next_ptr;
    logic        addr_active;
    logic        coord_valid;
    sprite_y_t   y_hold;

    assign next_ptr = word_ptr + 1'b1;

    // Held Y joined with the attribute word now on the read bus
    assign table_wr_attr = '{
        y:       y_hold,
        tile_id: oam_rdata[6:0],
        palette: oam_rdata[7],
        vflip:   oam_rdata[31],
        hflip:   oam_rdata[30]
    };

    always_ff @(posedge clk) begin
        if (reset) begin
            phase       <= LOAD_IDLE;
            word_ptr    <= '0;
            oam_addr    <= '0;
            addr_active <= 1'b0;
            coord_valid <= 1'b0;
            table_wr    <= 1'b0;
        end else begin
            // Read data trails the address by one cycle
            coord_valid <= addr_active & oam_addr[0];
            table_wr    <= addr_active & ~oam_addr[0];

            if (!vblank) begin
                phase       <= LOAD_IDLE;
                oam_addr    <= '0;
                addr_active <= 1'b0;
            end else begin
                case (phase)
                    LOAD_IDLE: begin
                        // Sprite 0 coordinate word goes out first
                        phase       <= LOAD_ACTIVE;
                        word_ptr    <= '0;
                        oam_addr    <= oam_addr_t'(1);
                        addr_active <= 1'b1;
                    end
                    LOAD_ACTIVE: begin
                        if (word_ptr == LAST_WORD) begin
                            phase       <= LOAD_DONE;
                            oam_addr    <= '0;
                            addr_active <= 1'b0;
                        end else begin
                            word_ptr <= next_ptr;
                            // Odd word of each pair ahead of the even one
                            oam_addr <= next_ptr ^ oam_addr_t'(1);
                        end
                    end
                    default: begin
                        // Wait here for vblank to drop
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        table_wr_index <= oam_addr[7:1];
        if (coord_valid) begin
            y_hold <= oam_rdata[31:16];
        end
    end

endmodule

// File: sprite_table.sv
`timescale 1ns/100ps

module sprite_table #(
    parameter int NUM_SPRITES = 128
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   table_wr,
    input  ppu_pkg::sprite_index_t table_wr_index,
    input  ppu_pkg::sprite_attr_t  table_wr_attr,
    input  ppu_pkg::sprite_index_t eval_index,
    input  ppu_pkg::sprite_index_t fetch_index,
    output ppu_pkg::sprite_attr_t  eval_attr,
    output ppu_pkg::sprite_attr_t  fetch_attr
);
    import ppu_pkg::*;

    sprite_attr_t entries [NUM_SPRITES];

    // Single write port from the loader
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_SPRITES; i++) begin
                entries[i] <= '0;
            end
        end else if (table_wr) begin
            entries[table_wr_index] <= table_wr_attr;
        end
    end

    // Evaluator and fetcher read without waiting a cycle
    assign eval_attr  = entries[eval_index];
    assign fetch_attr = entries[fetch_index];

endmodule

// File: sprite_evaluator.sv
`timescale 1ns/100ps

module sprite_evaluator #(
    parameter int NUM_SPRITES    = 128,
    parameter int SLOTS_PER_LINE = 8
) (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic                                        hsync,
    input  ppu_pkg::vcount_t                            vcount,
    output ppu_pkg::sprite_index_t                      eval_index,
    input  ppu_pkg::sprite_attr_t                       eval_attr,
    output ppu_pkg::sprite_index_t [SLOTS_PER_LINE-1:0] found_index,
    output ppu_pkg::slot_count_t                        found_count,
    output logic                                        eval_done
);
    import ppu_pkg::*;

    typedef enum logic [1:0] {
        EVAL_IDLE,
        EVAL_SCAN,
        EVAL_DONE
    } eval_state_t;

    localparam sprite_index_t LAST_INDEX = sprite_index_t'(NUM_SPRITES - 1);
    localparam slot_count_t   MAX_FOUND  = slot_count_t'(SLOTS_PER_LINE);

    eval_state_t   state;
    sprite_index_t scan_idx;
    logic [16:0]   y_end;
    logic          on_line;
    logic          record;

    assign eval_index = scan_idx;

    // One bit wider so a Y near the top does not wrap
    assign y_end   = {1'b0, eval_attr.y} + 17'(SPRITE_HEIGHT);
    assign on_line = (vcount >= eval_attr.y) && (vcount < y_end);

    // Later matches drop once all slots are taken
    assign record = (state == EVAL_SCAN) && hsync && on_line && (found_count < MAX_FOUND);

    always_ff @(posedge clk) begin
        if (reset) begin
            state       <= EVAL_IDLE;
            scan_idx    <= '0;
            found_count <= '0;
            eval_done   <= 1'b0;
        end else begin
            eval_done <= 1'b0;
            case (state)
                EVAL_IDLE: begin
                    if (hsync) begin
                        state       <= EVAL_SCAN;
                        scan_idx    <= '0;
                        found_count <= '0;
                    end
                end
                EVAL_SCAN: begin
                    if (!hsync) begin
                        state <= EVAL_IDLE;
                    end else begin
                        if (record) begin
                            found_count <= found_count + 1'b1;
                        end
                        if (scan_idx == LAST_INDEX) begin
                            state     <= EVAL_DONE;
                            eval_done <= 1'b1;
                        end else begin
                            scan_idx <= scan_idx + 1'b1;
                        end
                    end
                end
                default: begin
                    if (!hsync) begin
                        state <= EVAL_IDLE;
                    end
                end
            endcase
        end
    end

    // Lowest index lands in slot 0
    always_ff @(posedge clk) begin
        if (record) begin
            found_index[found_count] <= scan_idx;
        end
    end

endmodule

// File: sprite_fetcher.sv
`timescale 1ns/100ps

module sprite_fetcher #(
    parameter int SLOTS_PER_LINE = 8
) (
    input  logic                                        clk,
    input  logic                                        reset,
    input  logic                                        eval_done,
    input  ppu_pkg::vcount_t                            vcount,
    input  ppu_pkg::sprite_index_t [SLOTS_PER_LINE-1:0] found_index,
    input  ppu_pkg::slot_count_t                        found_count,
    output ppu_pkg::sprite_index_t                      fetch_index,
    input  ppu_pkg::sprite_attr_t                       fetch_attr,
    output ppu_pkg::gfx_addr_t                          gfx_addr,
    input  ppu_pkg::gfx_word_t                          gfx_rdata,
    output ppu_pkg::sprite_slot_t [SLOTS_PER_LINE-1:0]  sprite_slots,
    output ppu_pkg::slot_count_t                        sprite_count,
    output logic                                        shift_load_sprite
);
    import ppu_pkg::*;

    typedef enum logic [1:0] {
        FETCH_IDLE,
        FETCH_RUN,
        FETCH_DELIVER
    } fetch_state_t;

    // What the returning word needs to know about its slot
    typedef struct packed {
        slot_count_t slot;
        logic        used;
        logic        hflip;
        logic        palette;
    } slot_flags_t;

    localparam slot_count_t END_SLOT = slot_count_t'(SLOTS_PER_LINE);

    fetch_state_t state;
    slot_count_t  slot_ptr;
    logic         issue;
    logic         slot_used;
    logic         addr_valid;
    logic         data_valid;
    slot_flags_t  addr_flags;
    slot_flags_t  data_flags;
    sprite_row_t  row_raw;
    sprite_row_t  row;
    gfx_addr_t    row_addr;
    gfx_word_t    reversed;
    sprite_slot_t captured;
    sprite_slot_t [SLOTS_PER_LINE-1:0] staging;

    // Slot 0 already sits on fetch_index while idle
    assign issue = ((state == FETCH_IDLE) && eval_done) ||
                   ((state == FETCH_RUN) && (slot_ptr != END_SLOT));

    assign fetch_index = found_index[slot_ptr];
    assign slot_used   = slot_ptr < found_count;

    // Row inside the sprite, mirrored for vertical flip
    assign row_raw  = sprite_row_t'(vcount - fetch_attr.y);
    assign row      = fetch_attr.vflip ? sprite_row_t'(SPRITE_HEIGHT - 1) - row_raw : row_raw;
    // Same as tile id times 16 plus row
    assign row_addr = {fetch_attr.tile_id, row};

    always_comb begin
        for (int i = 0; i < $bits(gfx_word_t); i++) begin
            reversed[i] = gfx_rdata[$bits(gfx_word_t) - 1 - i];
        end
    end

    // Empty slots come out transparent
    always_comb begin
        captured = '0;
        if (data_flags.used) begin
            captured.palette = data_flags.palette;
            captured.pixels  = data_flags.hflip ? reversed : gfx_rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state             <= FETCH_IDLE;
            slot_ptr          <= '0;
            gfx_addr          <= '0;
            addr_valid        <= 1'b0;
            data_valid        <= 1'b0;
            shift_load_sprite <= 1'b0;
            sprite_count      <= '0;
            sprite_slots      <= '0;
        end else begin
            shift_load_sprite <= 1'b0;
            addr_valid        <= issue;
            data_valid        <= addr_valid;
            // No read goes out for an empty slot
            gfx_addr          <= (issue && slot_used) ? row_addr : '0;
            if (issue) begin
                slot_ptr <= slot_ptr + 1'b1;
            end

            case (state)
                FETCH_IDLE: begin
                    if (eval_done) begin
                        state <= FETCH_RUN;
                    end
                end
                FETCH_RUN: begin
                    if (slot_ptr == END_SLOT) begin
                        state <= FETCH_DELIVER;
                    end
                end
                default: begin
                    // Last slot's word is on the bus right now
                    sprite_slots                     <= staging;
                    sprite_slots[SLOTS_PER_LINE - 1] <= captured;
                    sprite_count                     <= found_count;
                    shift_load_sprite                <= 1'b1;
                    slot_ptr                         <= '0;
                    state                            <= FETCH_IDLE;
                end
            endcase
        end
    end

    // Flags follow the address, then line up with the read data
    always_ff @(posedge clk) begin
        if (issue) begin
            addr_flags <= '{
                slot:    slot_ptr,
                used:    slot_used,
                hflip:   fetch_attr.hflip,
                palette: fetch_attr.palette
            };
        end
        data_flags <= addr_flags;
        if (data_valid) begin
            staging[data_flags.slot] <= captured;
        end
    end

endmodule

// File: ppu_sprite_top.sv
`timescale 1ns/100ps

module ppu_sprite_top #(
    parameter int NUM_SPRITES    = 128,
    parameter int SLOTS_PER_LINE = 8
) (
    input  logic                                       clk,
    input  logic                                       reset,
    input  logic                                       vblank,
    input  logic                                       hsync,
    input  ppu_pkg::vcount_t                           vcount,
    input  ppu_pkg::oam_word_t                         oam_rdata,
    input  ppu_pkg::gfx_word_t                         gfx_rdata,
    output ppu_pkg::oam_addr_t                         oam_addr,
    output ppu_pkg::gfx_addr_t                         gfx_addr,
    output ppu_pkg::sprite_slot_t [SLOTS_PER_LINE-1:0] sprite_slots,
    output ppu_pkg::slot_count_t                       sprite_count,
    output logic                                       shift_load_sprite
);
    import ppu_pkg::*;

    // Loader to table
    logic          table_wr;
    sprite_index_t table_wr_index;
    sprite_attr_t  table_wr_attr;

    // Table read ports
    sprite_index_t eval_index;
    sprite_index_t fetch_index;
    sprite_attr_t  eval_attr;
    sprite_attr_t  fetch_attr;

    // Evaluator to fetcher
    sprite_index_t [SLOTS_PER_LINE-1:0] found_index;
    slot_count_t                        found_count;
    logic                               eval_done;

    // Once per frame
    oam_loader #(
        .NUM_SPRITES (NUM_SPRITES)
    ) u_loader (
        .clk            (clk),
        .reset          (reset),
        .vblank         (vblank),
        .oam_rdata      (oam_rdata),
        .oam_addr       (oam_addr),
        .table_wr       (table_wr),
        .table_wr_index (table_wr_index),
        .table_wr_attr  (table_wr_attr)
    );

    sprite_table #(
        .NUM_SPRITES (NUM_SPRITES)
    ) u_table (
        .clk            (clk),
        .reset          (reset),
        .table_wr       (table_wr),
        .table_wr_index (table_wr_index),
        .table_wr_attr  (table_wr_attr),
        .eval_index     (eval_index),
        .fetch_index    (fetch_index),
        .eval_attr      (eval_attr),
        .fetch_attr     (fetch_attr)
    );

    // Once per line, detect then fetch
    sprite_evaluator #(
        .NUM_SPRITES    (NUM_SPRITES),
        .SLOTS_PER_LINE (SLOTS_PER_LINE)
    ) u_evaluator (
        .clk         (clk),
        .reset       (reset),
        .hsync       (hsync),
        .vcount      (vcount),
        .eval_index  (eval_index),
        .eval_attr   (eval_attr),
        .found_index (found_index),
        .found_count (found_count),
        .eval_done   (eval_done)
    );

    sprite_fetcher #(
        .SLOTS_PER_LINE (SLOTS_PER_LINE)
    ) u_fetcher (
        .clk               (clk),
        .reset             (reset),
        .eval_done         (eval_done),
        .vcount            (vcount),
        .found_index       (found_index),
        .found_count       (found_count),
        .fetch_index       (fetch_index),
        .fetch_attr        (fetch_attr),
        .gfx_addr          (gfx_addr),
        .gfx_rdata         (gfx_rdata),
        .sprite_slots      (sprite_slots),
        .sprite_count      (sprite_count),
        .shift_load_sprite (shift_load_sprite)
    );

endmodule

// File: ppu_sprite_properties.sv
`timescale 1ns/100ps

module ppu_sprite_properties (
    input logic               clk,
    input logic               reset,
    input logic               vblank,
    input logic               hsync,
    input ppu_pkg::oam_addr_t oam_addr,
    input ppu_pkg::gfx_addr_t gfx_addr,
    input logic               shift_load_sprite
);

    int unsigned fail_count = 0;

    // Quiet outputs one cycle into reset
    reset_idle: assert property (@(posedge clk)
        $past(reset) |-> !shift_load_sprite && oam_addr == '0 && gfx_addr == '0)
    else begin
        fail_count++;
        $error("outputs not idle during reset");
    end

    // Load opens on the coordinate word of sprite 0
    load_start: assert property (@(posedge clk) disable iff (reset)
        $rose(vblank) |=> oam_addr == 8'd1)
    else begin
        fail_count++;
        $error("OAM load did not start at address 1");
    end

    // Coordinate word then attribute word
    odd_step: assert property (@(posedge clk) disable iff (reset)
        vblank && oam_addr[0] |=> oam_addr == $past(oam_addr) - 8'd1)
    else begin
        fail_count++;
        $error("OAM address did not step down to the attribute word");
    end

    even_step: assert property (@(posedge clk) disable iff (reset)
        vblank && !oam_addr[0] && $past(oam_addr[0])
        |=> oam_addr == (($past(oam_addr) == 8'd254) ? 8'd0 : $past(oam_addr) + 8'd3))
    else begin
        fail_count++;
        $error("OAM address did not move to the next sprite");
    end

    // Parked at zero once the table is full
    load_hold: assert property (@(posedge clk) disable iff (reset)
        vblank && $past(vblank) && oam_addr == '0 && $past(oam_addr) != 8'd1
        |=> oam_addr == '0)
    else begin
        fail_count++;
        $error("OAM address moved after the load finished");
    end

    pulse_in_hsync: assert property (@(posedge clk) disable iff (reset)
        shift_load_sprite |-> hsync && !vblank)
    else begin
        fail_count++;
        $error("shift_load_sprite outside hsync");
    end

    pulse_single: assert property (@(posedge clk) disable iff (reset)
        shift_load_sprite |=> !shift_load_sprite)
    else begin
        fail_count++;
        $error("shift_load_sprite longer than one cycle");
    end

endmodule

bind ppu_sprite_top ppu_sprite_properties props (
    .clk               (clk),
    .reset             (reset),
    .vblank            (vblank),
    .hsync             (hsync),
    .oam_addr          (oam_addr),
    .gfx_addr          (gfx_addr),
    .shift_load_sprite (shift_load_sprite)
);

// File: tb_ppu_sprite.sv
`timescale 1ns/100ps

module tb_ppu_sprite;
    import ppu_pkg::*;

    localparam int NUM_SPRITES    = 128;
    localparam int SLOTS_PER_LINE = 8;
    localparam int HSYNC_CYCLES   = 200;
    localparam int HBLANK_CYCLES  = 20;
    localparam int VBLANK_CYCLES  = 300;

    logic                              clk = 1'b0;
    logic                              reset;
    logic                              vblank;
    logic                              hsync;
    vcount_t                           vcount;
    oam_word_t                         oam_rdata = '0;
    gfx_word_t                         gfx_rdata = '0;
    oam_addr_t                         oam_addr;
    gfx_addr_t                         gfx_addr;
    sprite_slot_t [SLOTS_PER_LINE-1:0] sprite_slots;
    slot_count_t                       sprite_count;
    logic                              shift_load_sprite;

    oam_word_t oam_mem [256];
    gfx_word_t gfx_mem [2048];

    // Crowded, sparse and empty lines
    vcount_t line_list [8] = '{10'd5, 10'd30, 10'd45, 10'd120,
                               10'd250, 10'd400, 10'd520, 10'd700};

    always #5 clk = ~clk;

    ppu_sprite_top #(
        .NUM_SPRITES    (NUM_SPRITES),
        .SLOTS_PER_LINE (SLOTS_PER_LINE)
    ) uut (
        .clk               (clk),
        .reset             (reset),
        .vblank            (vblank),
        .hsync             (hsync),
        .vcount            (vcount),
        .oam_rdata         (oam_rdata),
        .gfx_rdata         (gfx_rdata),
        .oam_addr          (oam_addr),
        .gfx_addr          (gfx_addr),
        .sprite_slots      (sprite_slots),
        .sprite_count      (sprite_count),
        .shift_load_sprite (shift_load_sprite)
    );

    // Both memories answer one cycle after the address
    always @(posedge clk) begin
        oam_rdata <= oam_mem[oam_addr];
        gfx_rdata <= gfx_mem[gfx_addr];
    end

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    // Bound property failures end the run at once
    always @(posedge clk) begin
        if (uut.props.fail_count != 0) begin
            $display("Bound property check failed before %0t ns", $time);
            abort_run();
        end
    end

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        abort_run();
    endtask

    // First 40 sprites pile up near the top, the rest spread out
    task automatic fill_oam();
        int y;
        for (int i = 0; i < NUM_SPRITES; i++) begin
            y = (i < 40) ? int'($urandom % 48) : 100 + int'($urandom % 400);
            oam_mem[2 * i + 1] = {y[15:0], 16'($urandom)};
            oam_mem[2 * i]     = $urandom;
        end
    endtask

    // Reference slots straight from the memory contents
    function automatic void expected_line(input int v, output int count,
                                          output sprite_slot_t [SLOTS_PER_LINE-1:0] slots);
        int        y;
        int        row;
        oam_word_t attr;
        gfx_word_t word;
        count = 0;
        slots = '0;
        for (int i = 0; i < NUM_SPRITES; i++) begin
            y = int'(oam_mem[2 * i + 1][31:16]);
            if (count < SLOTS_PER_LINE && v >= y && v < y + 16) begin
                attr = oam_mem[2 * i];
                row  = attr[31] ? 15 - (v - y) : v - y;
                word = gfx_mem[int'(attr[6:0]) * 16 + row];
                if (attr[30]) begin
                    word = {<<{word}};
                end
                slots[count] = '{palette: attr[7], pixels: word};
                count++;
            end
        end
    endfunction

    task automatic check_outputs(input vcount_t v);
        int                                exp_count;
        sprite_slot_t [SLOTS_PER_LINE-1:0] exp_slots;
        expected_line(int'(v), exp_count, exp_slots);
        assert (int'(sprite_count) == exp_count)
            else report_mismatch("sprite_count", 64'(exp_count), 64'(sprite_count));
        // Unused slots must come out transparent
        for (int s = 0; s < SLOTS_PER_LINE; s++) begin
            assert (sprite_slots[s] == exp_slots[s])
                else report_mismatch($sformatf("sprite_slots[%0d]", s),
                                     64'(exp_slots[s]), 64'(sprite_slots[s]));
        end
    endtask

    task automatic expect_no_pulse(input vcount_t v, input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            assert (!shift_load_sprite) else begin
                $display("Error at %0t ns: extra shift_load_sprite pulse on line %0d", $time, v);
                abort_run();
            end
        end
    endtask

    task automatic scan_line(input vcount_t v);
        int   cycles;
        logic seen;
        vcount <= v;
        hsync  <= 1'b1;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < HSYNC_CYCLES) begin
            @(posedge clk);
            cycles++;
            seen = shift_load_sprite;
        end
        assert (seen) else begin
            $display("Timeout: no shift_load_sprite within %0d cycles on line %0d",
                     HSYNC_CYCLES, v);
            abort_run();
        end
        check_outputs(v);
        expect_no_pulse(v, HSYNC_CYCLES - cycles);
        hsync <= 1'b0;
        expect_no_pulse(v, HBLANK_CYCLES);
    endtask

    task automatic play_frame();
        fill_oam();
        vblank <= 1'b1;
        repeat (VBLANK_CYCLES) @(posedge clk);
        vblank <= 1'b0;
        repeat (HBLANK_CYCLES) @(posedge clk);
        foreach (line_list[i]) begin
            scan_line(line_list[i]);
        end
    endtask

    initial begin
        int seed_state;
        seed_state = $urandom(32'h585abb68);
        reset  = 1'b1;
        vblank = 1'b0;
        hsync  = 1'b0;
        vcount = '0;
        foreach (gfx_mem[a]) begin
            gfx_mem[a] = $urandom;
        end
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        // Second frame reloads the table with new contents
        repeat (2) play_frame();
        if (uut.props.fail_count == 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            $display("Error: %0d bound property checks failed", uut.props.fail_count);
            abort_run();
        end
    end

endmodule

// File: vlog.f
ppu_pkg.sv
oam_loader.sv
sprite_table.sv
sprite_evaluator.sv
sprite_fetcher.sv
ppu_sprite_top.sv
ppu_sprite_properties.sv
tb_ppu_sprite.sv

// File: run_sim.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
verilator --binary --timing --assert --top-module tb_ppu_sprite -f vlog.f \
    && ./obj_dir/Vtb_ppu_sprite | tee /dev/stderr | grep -q "^PASS: all tests$" \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
